// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_fp_log
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
ERR_LIMIT ?= 100
SIM_ARGS  ?= +verilator+error+limit+$(ERR_LIMIT)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)

// ==== exponent_term.sv ====
// exponent to float conversion and e*ln2 through the shared fpu
`timescale 1ns/10ps
`include "fp_log_params.svh"

module exponent_term (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             start,
  input  fp_log_pkg::exp_t  exp,
  fpu_if.requester         fpu,
  output fp_log_pkg::fp32_t exp_val,
  output logic             exp_valid
);
  import fp_log_pkg::*;

  exp_state_e state;
  fp32_t e_float;
  fp32_t e_conv;

  // priority normalizer on |e|
  always_comb begin
    logic [8:0] mag;
    logic [3:0] pos;
    logic [31:0] sh;
    mag = exp[8] ? 9'(-exp) : 9'(exp);
    pos = '0;
    for (int k = 0; k < 9; k++) begin
      if (mag[k]) pos = k[3:0];
    end
    sh = 32'(mag) << (5'd23 - 5'(pos));
    e_conv = {exp[8], 8'(`EXP_BIAS + pos), sh[22:0]};
  end

  assign fpu.req = (state == EXP_REQ);
  assign fpu.op  = OP_MUL;
  assign fpu.a   = e_float;
  assign fpu.b   = `LN2_BITS;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= EXP_IDLE;
      exp_valid <= 1'b0;
    end else if (start && (state == EXP_IDLE || state == EXP_HOLD)) begin
      exp_valid <= (exp == '0);  // zero exponent needs no multiply
      state     <= (exp == '0) ? EXP_HOLD : EXP_REQ;
    end else if (state == EXP_REQ && fpu.gnt) begin
      state <= EXP_WAIT;
    end else if (state == EXP_WAIT && fpu.done) begin
      exp_valid <= 1'b1;
      state     <= EXP_HOLD;
    end
  end

  always_ff @(posedge clk) begin
    if (start && (state == EXP_IDLE || state == EXP_HOLD)) begin
      e_float <= e_conv;
      exp_val <= '0;
    end else if (state == EXP_WAIT && fpu.done) begin
      exp_val <= fpu.result;
    end
  end

endmodule

// ==== fp_log.sv ====
// float32 natural log top: decode, special cases, sequencers and shared fpu
`timescale 1ns/10ps
`include "fp_log_params.svh"

module fp_log (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start,
  input  fp_log_pkg::fp32_t  x,
  output fp_log_pkg::fp32_t  result,
  output logic              done,
  output logic              busy
);
  import fp_log_pkg::*;

  logic [`EXP_W-1:0] ex;
  logic [`FRAC_W-1:0] fr;
  logic special;
  logic launch;
  fp32_t spec_val;
  fp32_t sig;
  fp32_t exp_val;
  fp32_t sum;
  exp_t e;
  tbl_idx_t idx;
  logic exp_valid;
  logic ser_done;

  fpu_if ser_port ();
  fpu_if exp_port ();
  fpu_if unit_port ();

  assign ex  = x[30:23];
  assign fr  = x[22:0];
  assign sig = {1'b0, 8'(`EXP_BIAS), fr};  // s in [1,2)
  assign e   = exp_t'(ex) - `EXP_BIAS;
  assign idx = fr[`FRAC_W-1 -: `TBL_BITS];

  // zero and subnormals flush to -inf, nan before sign
  assign special = (ex == '0) || x[31] || (ex == '1);
  always_comb begin
    if (ex == '1 && fr != '0) spec_val = 32'h7fc00000;
    else if (ex == '0)        spec_val = 32'hff800000;
    else if (x[31])           spec_val = 32'h7fc00000;
    else                      spec_val = 32'h7f800000;
  end

  assign launch = start && !busy && !special;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
      done <= 1'b0;
    end else begin
      done <= (start && !busy && special) || ser_done;
      if (start && !busy) busy <= 1'b1;
      else if (done)      busy <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (start && !busy && special) result <= spec_val;
    else if (ser_done)             result <= sum;
  end

  series_eval i_series (
    .clk, .rst_n, .start(launch), .sig, .idx, .exp_val, .exp_valid,
    .fpu(ser_port.requester), .sum, .done(ser_done)
  );

  exponent_term i_exp (
    .clk, .rst_n, .start(launch), .exp(e), .fpu(exp_port.requester), .exp_val, .exp_valid
  );

  fpu_arbiter i_arb (
    .clk, .rst_n, .req_series(ser_port.arbiter_side), .req_exp(exp_port.arbiter_side),
    .unit(unit_port.requester)
  );

  fp_unit i_fpu (.clk, .rst_n, .port(unit_port.unit));

endmodule

// ==== fp_log_params.svh ====
// float32 field widths, bias, table size
// coefficient and ln2 bit patterns
`ifndef FP_LOG_PARAMS_SVH
`define FP_LOG_PARAMS_SVH

`define FP_W      32
`define EXP_W     8
`define FRAC_W    23
`define EXP_BIAS  127

// fraction bits used as table index
`define TBL_BITS  4

// series coefficients, ln(1+t) = t*(1 + t*(-1/2 + t*(1/3 - t/4)))
`define LN2_BITS      32'h3f317218
`define C_HALF_NEG    32'hbf000000
`define C_THIRD       32'h3eaaaaab
`define C_QUARTER_NEG 32'hbe800000
`define ONE_BITS      32'h3f800000

`endif

// ==== fp_log_pkg.sv ====
// shared types for the log unit
// float word, exponent, table index, fpu op and FSM states
`include "fp_log_params.svh"

package fp_log_pkg;

  typedef logic [`FP_W-1:0] fp32_t;
  typedef logic signed [`EXP_W:0] exp_t;  // unbiased, one bit wider than field
  typedef logic [`TBL_BITS-1:0] tbl_idx_t;

  typedef enum logic {
    OP_MUL,
    OP_ADD
  } fpu_op_e;

  typedef enum logic [1:0] {
    SER_IDLE,
    SER_REQ,
    SER_WAIT
  } series_state_e;

  typedef enum logic [1:0] {
    EXP_IDLE,
    EXP_REQ,
    EXP_WAIT,
    EXP_HOLD
  } exp_state_e;

endpackage

// ==== fp_log_props.sv ====
// bound checks for fp_log: done and busy protocol, special results, accuracy
`timescale 1ns/10ps
`include "fp_log_params.svh"

module fp_log_props (
  input logic              clk,
  input logic              rst_n,
  input logic              start,
  input fp_log_pkg::fp32_t x,
  input fp_log_pkg::fp32_t result,
  input logic              done,
  input logic              busy,
  input logic [63:0]       ref_bits  // ln of the accepted x, real bits
);
  import fp_log_pkg::*;

  localparam real TOL_ABS = 2.0 ** (-20);
  localparam real TOL_REL = 2.0 ** (-16);

  fp32_t x_q;             // x of the operation in progress
  logic failed = 1'b0;    // sticky, watched by the testbench

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      x_q <= '0;
    end else if (start && !busy) begin
      x_q <= x;
    end
  end

  function automatic bit is_special(input fp32_t v);
    return v[30:23] == 8'h00 || v[30:23] == 8'hff || v[31];
  endfunction

  // zero -> -inf, +inf -> +inf, everything else special -> quiet nan
  function automatic bit special_ok(input fp32_t v, input fp32_t r);
    if (v[30:23] == 8'h00) return r == 32'hff800000;
    if (v == 32'h7f800000) return r == 32'h7f800000;
    return r[30:22] == 9'h1ff;
  endfunction

  function automatic real to_real(input fp32_t v);
    real mag;
    if (v[30:23] == 8'h00) return 0.0;
    mag = (1.0 + real'(v[22:0]) / 8388608.0) * (2.0 ** (real'(v[30:23]) - 127.0));
    return v[31] ? -mag : mag;
  endfunction

  function automatic bit within_tol(input fp32_t r, input logic [63:0] rb);
    real want;
    real diff;
    real tol;
    want = $bitstoreal(rb);
    diff = to_real(r) - want;
    if (diff < 0.0) diff = -diff;
    tol = TOL_REL * ((want < 0.0) ? -want : want);
    if (tol < TOL_ABS) tol = TOL_ABS;
    return diff <= tol;
  endfunction

  a_reset_idle: assert property (@(posedge clk) !rst_n |-> !done && !busy)
    else begin
      $error("error at %0t: done or busy high during reset", $time);
      failed = 1'b1;
    end

  a_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
    start && !busy |=> busy)
    else begin
      $error("error at %0t: busy not raised after start", $time);
      failed = 1'b1;
    end

  a_busy_hold: assert property (@(posedge clk) disable iff (!rst_n)
    busy && !done |=> busy)
    else begin
      $error("error at %0t: busy dropped before done", $time);
      failed = 1'b1;
    end

  a_done_in_busy: assert property (@(posedge clk) disable iff (!rst_n) done |-> busy)
    else begin
      $error("error at %0t: done pulse while idle", $time);
      failed = 1'b1;
    end

  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    done |=> !done && !busy)
    else begin
      $error("error at %0t: done longer than one cycle or busy stuck", $time);
      failed = 1'b1;
    end

  a_special: assert property (@(posedge clk) disable iff (!rst_n)
    start && !busy && is_special(x) |=> done && special_ok(x_q, result))
    else begin
      $error("error at %0t: special input %h gave %h", $time, x_q, result);
      failed = 1'b1;
    end

  a_one_exact: assert property (@(posedge clk) disable iff (!rst_n)
    done && x_q == `ONE_BITS |-> result == '0)
    else begin
      $error("error at %0t: ln(1.0) gave %h, not +0", $time, result);
      failed = 1'b1;
    end

  a_accuracy: assert property (@(posedge clk) disable iff (!rst_n)
    done && !is_special(x_q) |-> within_tol(result, ref_bits))
    else begin
      $error("error at %0t: ln(%h) gave %h, expected %g", $time, x_q, result,
             $bitstoreal(ref_bits));
      failed = 1'b1;
    end

  a_idle_hold: assert property (@(posedge clk) disable iff (!rst_n)
    !busy && !start |=> $stable(result))
    else begin
      $error("error at %0t: result changed while idle", $time);
      failed = 1'b1;
    end

endmodule

// ==== fp_unit.sv ====
// shared truncating float32 multiplier and adder
// result and done registered one cycle after grant
`timescale 1ns/10ps
`include "fp_log_params.svh"

module fp_unit (
  input logic clk,
  input logic rst_n,
  fpu_if.unit port
);
  import fp_log_pkg::*;

  fp32_t mul_res;
  fp32_t add_res;

  assign port.gnt = port.req;  // never stalls

  // multiply of normal operands only
  always_comb begin
    logic [`EXP_W-1:0] ea;
    logic [`EXP_W-1:0] eb;
    logic [47:0] prod;
    logic [`FRAC_W-1:0] frac;
    exp_t em;
    ea = port.a[30:23];
    eb = port.b[30:23];
    prod = {1'b1, port.a[22:0]} * {1'b1, port.b[22:0]};
    em = exp_t'(ea) - `EXP_BIAS + exp_t'(eb) - `EXP_BIAS;
    if (prod[47]) begin
      frac = prod[46:24];
      em = em + 1;
    end else begin
      frac = prod[45:23];
    end
    if (ea == '0 || eb == '0 || em < -126) begin
      mul_res = '0;  // zero operand or flushed underflow
    end else begin
      mul_res = {port.a[31] ^ port.b[31], 8'(em + `EXP_BIAS), frac};
    end
  end

  // add with 3 guard bits and leading-one normalize
  always_comb begin
    fp32_t big;
    fp32_t smaller;
    logic [7:0] d;
    logic [26:0] sa;
    logic [26:0] sb;
    logic [27:0] sum;
    logic [27:0] norm;
    logic [4:0] lead;
    logic signed [9:0] ez;
    if (port.a[30:0] < port.b[30:0]) begin
      big = port.b;
      smaller = port.a;
    end else begin
      big = port.a;
      smaller = port.b;
    end
    d = big[30:23] - smaller[30:23];
    sa = {big[30:23] != '0, big[22:0], 3'b000};
    sb = {smaller[30:23] != '0, smaller[22:0], 3'b000};
    sb = (d > 8'd26) ? '0 : sb >> d;
    if (big[31] != smaller[31]) begin
      sum = {1'b0, sa} - {1'b0, sb};
    end else begin
      sum = {1'b0, sa} + {1'b0, sb};
    end
    lead = '0;
    for (int k = 0; k < 28; k++) begin
      if (sum[k]) lead = k[4:0];
    end
    norm = sum << (5'd27 - lead);
    ez = $signed({2'b00, big[30:23]}) + $signed({5'b00000, lead}) - 10'sd26;
    if (sum == '0 || ez <= 0) begin
      add_res = '0;  // cancellation gives +0
    end else begin
      add_res = {big[31], ez[7:0], norm[26:4]};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      port.done <= 1'b0;
    end else begin
      port.done <= port.req;
    end
  end

  always_ff @(posedge clk) begin
    if (port.req) port.result <= (port.op == OP_MUL) ? mul_res : add_res;
  end

endmodule

// ==== fpu_arbiter.sv ====
// round-robin arbiter for the shared fpu, one operation in flight
`timescale 1ns/10ps

module fpu_arbiter (
  input logic clk,
  input logic rst_n,
  fpu_if.arbiter_side req_series,
  fpu_if.arbiter_side req_exp,
  fpu_if.requester unit
);
  import fp_log_pkg::*;

  logic busy_q;
  logic owner_q;  // 1 when exponent port owns the operation
  logic last_q;   // 1 when exponent port won last
  logic grant_s;
  logic grant_e;

  assign grant_s = !busy_q && req_series.req && (!req_exp.req || last_q);
  assign grant_e = !busy_q && req_exp.req && (!req_series.req || !last_q);

  assign unit.req = grant_s | grant_e;
  assign unit.op  = grant_e ? req_exp.op : req_series.op;
  assign unit.a   = grant_e ? req_exp.a : req_series.a;
  assign unit.b   = grant_e ? req_exp.b : req_series.b;

  assign req_series.gnt = grant_s & unit.gnt;
  assign req_exp.gnt    = grant_e & unit.gnt;

  // result goes back to whoever issued it
  assign req_series.done   = unit.done && !owner_q;
  assign req_exp.done      = unit.done && owner_q;
  assign req_series.result = unit.result;
  assign req_exp.result    = unit.result;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q  <= 1'b0;
      owner_q <= 1'b0;
      last_q  <= 1'b1;  // series first
    end else if (unit.req && unit.gnt) begin
      busy_q  <= 1'b1;
      owner_q <= grant_e;
      last_q  <= grant_e;
    end else if (unit.done) begin
      busy_q <= 1'b0;
    end
  end

endmodule

// ==== fpu_if.sv ====
// request/result link to the shared arithmetic unit
`timescale 1ns/10ps

interface fpu_if;
  import fp_log_pkg::*;

  logic    req;     // held until gnt
  fpu_op_e op;
  fp32_t   a;
  fp32_t   b;
  logic    gnt;     // one-cycle accept
  logic    done;    // result valid
  fp32_t   result;

  modport requester (output req, op, a, b, input gnt, done, result);

  modport arbiter_side (input req, op, a, b, output gnt, done, result);

  // unit is always ready, so it answers req with gnt directly
  modport unit (input req, op, a, b, output gnt, done, result);

endinterface

// ==== series_eval.sv ====
// reciprocal and ln tables, range reduction, Horner series, final sums
`timescale 1ns/10ps
`include "fp_log_params.svh"

module series_eval (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start,
  input  fp_log_pkg::fp32_t    sig,
  input  fp_log_pkg::tbl_idx_t idx,
  input  fp_log_pkg::fp32_t    exp_val,
  input  logic                exp_valid,
  fpu_if.requester            fpu,
  output fp_log_pkg::fp32_t    sum,
  output logic                done
);
  import fp_log_pkg::*;

  localparam logic [3:0] LAST_STEP = 4'd10;

  series_state_e state;
  logic [3:0] step;
  fp32_t sig_q;
  tbl_idx_t idx_q;
  fp32_t acc;
  fp32_t t_q;  // m - 1
  fp32_t recip;
  fp32_t ln_tbl;

  // 1/(1+i/16)
  always_comb begin
    case (idx_q)
      4'd0:  recip = 32'h3f800000;
      4'd1:  recip = 32'h3f70f0f0;
      4'd2:  recip = 32'h3f638e38;
      4'd3:  recip = 32'h3f579435;
      4'd4:  recip = 32'h3f4ccccc;
      4'd5:  recip = 32'h3f430c30;
      4'd6:  recip = 32'h3f3a2e8b;
      4'd7:  recip = 32'h3f321642;
      4'd8:  recip = 32'h3f2aaaaa;
      4'd9:  recip = 32'h3f23d70a;
      4'd10: recip = 32'h3f1d89d8;
      4'd11: recip = 32'h3f17b425;
      4'd12: recip = 32'h3f124924;
      4'd13: recip = 32'h3f0d3dcb;
      4'd14: recip = 32'h3f088888;
      default: recip = 32'h3f042108;
    endcase
  end

  // ln(1+i/16)
  always_comb begin
    case (idx_q)
      4'd0:  ln_tbl = 32'h00000000;
      4'd1:  ln_tbl = 32'h3d785186;
      4'd2:  ln_tbl = 32'h3df1383d;
      4'd3:  ln_tbl = 32'h3e2ff983;
      4'd4:  ln_tbl = 32'h3e647fbe;
      4'd5:  ln_tbl = 32'h3e8b3ae5;
      4'd6:  ln_tbl = 32'h3ea30c5e;
      4'd7:  ln_tbl = 32'h3eb9cebe;
      4'd8:  ln_tbl = 32'h3ecf991f;
      4'd9:  ln_tbl = 32'h3ee47fbe;
      4'd10: ln_tbl = 32'h3ef8947b;
      4'd11: ln_tbl = 32'h3f05f397;
      4'd12: ln_tbl = 32'h3f0f42fa;
      4'd13: ln_tbl = 32'h3f183eb9;
      4'd14: ln_tbl = 32'h3f20ec7f;
      default: ln_tbl = 32'h3f295169;
    endcase
  end

  // operation issued at each step
  always_comb begin
    fpu.op = OP_ADD;
    fpu.a  = acc;
    fpu.b  = t_q;
    case (step)
      4'd0: begin
        fpu.op = OP_MUL;
        fpu.a  = sig_q;
        fpu.b  = recip;
      end
      4'd1: fpu.b = {1'b1, 31'(`ONE_BITS)};  // m + (-1)
      4'd2: begin
        fpu.op = OP_MUL;
        fpu.b  = `C_QUARTER_NEG;
      end
      4'd3: fpu.b = `C_THIRD;
      4'd5: fpu.b = `C_HALF_NEG;
      4'd7: fpu.b = `ONE_BITS;
      4'd4, 4'd6, 4'd8: fpu.op = OP_MUL;  // times t
      4'd9: fpu.b = ln_tbl;
      default: fpu.b = exp_val;
    endcase
  end

  // final add waits for the exponent term
  assign fpu.req = (state == SER_REQ) && (step != LAST_STEP || exp_valid);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= SER_IDLE;
      step  <= '0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        SER_IDLE: if (start) begin
          step  <= '0;
          state <= SER_REQ;
        end
        SER_REQ: if (fpu.req && fpu.gnt) state <= SER_WAIT;
        default: if (fpu.done) begin
          if (step == LAST_STEP) begin
            done  <= 1'b1;
            state <= SER_IDLE;
          end else begin
            step  <= step + 4'd1;
            state <= SER_REQ;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == SER_IDLE && start) begin
      sig_q <= sig;
      idx_q <= idx;
    end
    if (state == SER_WAIT && fpu.done) begin
      acc <= fpu.result;
      if (step == 4'd1) t_q <= fpu.result;
      if (step == LAST_STEP) sum <= fpu.result;
    end
  end

endmodule

// ==== tb_fp_log.sv ====
// testbench for fp_log with clock, reset, LFSR stimulus, ln reference and timeout
`timescale 1ns/10ps

module tb_fp_log;
  import fp_log_pkg::*;

  localparam int N_RANDOM   = 240;
  localparam int N_TESTS    = 7 + 1 + 41 + N_RANDOM + 3;
  localparam int MAX_CYCLES = N_TESTS * 200;

  logic clk;
  logic rst_n;
  logic start;
  fp32_t x;
  fp32_t result;
  logic done;
  logic busy;
  logic [63:0] ref_bits;  // $ln of the last accepted x
  logic [15:0] lfsr;
  int cycles = 0;

  fp32_t specials [7] = '{32'h00000000, 32'h80000000, 32'h00012345, 32'hc0000000,
                          32'h7f800000, 32'h7f800001, 32'hffc00000};

  fp_log i_dut (.clk, .rst_n, .start, .x, .result, .done, .busy);

  bind fp_log fp_log_props i_props (
    .clk(clk), .rst_n(rst_n), .start(start), .x(x), .result(result),
    .done(done), .busy(busy), .ref_bits(tb_fp_log.ref_bits)
  );

  always #5 clk = ~clk;

  // run limit and assertion watch
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("TESTBENCH FAILED");
      $fatal(1, "timeout: run did not finish within %0d cycles", MAX_CYCLES);
    end else if (i_dut.i_props.failed) begin
      $display("TESTBENCH FAILED");
      $fatal(1, "a bound assertion on fp_log failed");
    end
  end

  // galois form with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  function automatic real ln_of(input fp32_t v);
    real mag;
    if (v[30:23] == 8'h00 || v[30:23] == 8'hff || v[31]) return 0.0;  // not checked
    mag = (1.0 + real'(v[22:0]) / 8388608.0) * (2.0 ** (real'(v[30:23]) - 127.0));
    return $ln(mag);
  endfunction

  // one operation with an optional second start while busy
  task automatic run_one(input fp32_t v, input bit intrude, input fp32_t other);
    @(negedge clk);
    while (busy) @(negedge clk);
    @(negedge clk);  // idle cycle between operations
    x = v;
    start = 1'b1;
    ref_bits = $realtobits(ln_of(v));
    @(negedge clk);
    start = 1'b0;
    if (intrude) begin
      repeat (3) @(negedge clk);
      x = other;
      start = 1'b1;  // must be ignored
      @(negedge clk);
      start = 1'b0;
    end
    while (!done) @(negedge clk);
  endtask

  initial begin
    logic [31:0] r;
    logic [7:0] e;
    fp32_t v;
    clk = 1'b0;
    rst_n = 1'b0;
    start = 1'b0;
    x = '0;
    ref_bits = '0;
    lfsr = 16'd46851;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    foreach (specials[i]) run_one(specials[i], 1'b0, '0);
    run_one(32'h3f800000, 1'b0, '0);

    for (int k = -20; k <= 20; k++) begin
      run_one({1'b0, 8'(127 + k), 23'd0}, 1'b0, '0);
    end

    for (int n = 0; n < N_RANDOM; n++) begin
      take_bits(2, r);
      if (r[1:0] == 2'd0) begin
        take_bits(12, r);
        v = {1'b0, 8'd126, 23'h7fffff - 23'(r[11:0])};  // just below 1
      end else if (r[1:0] == 2'd1) begin
        take_bits(12, r);
        v = {1'b0, 8'd127, 23'(r[11:0])};  // just above 1
      end else begin
        take_bits(8, r);
        e = r[7:0];
        if (e == 8'h00) e = 8'h01;
        if (e == 8'hff) e = 8'hfe;
        take_bits(23, r);
        v = {1'b0, e, r[22:0]};
      end
      run_one(v, 1'b0, '0);
    end

    run_one(32'h40600000, 1'b1, 32'h00000000);
    run_one(32'h3dcccccd, 1'b1, 32'h42c80000);
    run_one(32'h501502f9, 1'b1, 32'hbf800000);

    repeat (3) @(negedge clk);
    if (i_dut.i_props.failed) begin
      $display("TESTBENCH FAILED");
      $fatal(1, "a bound assertion on fp_log failed");
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

// ==== verilog.f ====
+incdir+.
fp_log_pkg.sv
fpu_if.sv
fp_unit.sv
fpu_arbiter.sv
series_eval.sv
exponent_term.sv
fp_log.sv
fp_log_props.sv
tb_fp_log.sv
